// ==== hdl/io_bus_config.svh ====
`ifndef IO_BUS_CONFIG_SVH
`define IO_BUS_CONFIG_SVH

// ----------------------------------------
// bus geometry
// ----------------------------------------
`define IO_ADDR_W	16		// io address width
`define IO_DATA_W	8		// data byte width
`define IO_PAGE_W	8		// high address byte, selects the device

// ----------------------------------------
// device pages and bus-free value
// ----------------------------------------
`define IO_SPI_PAGE	8'h0E	// mmc serial window
`define IO_PPI_PAGE	8'h1A	// 8255 parallel port
`define IO_BUS_FREE	8'hFF	// pulled-up bus, unmapped reads

// ----------------------------------------
// serial shifter
// ----------------------------------------
`define SPI_CNT_W	4		// bit counter, 0..15 bits per transfer
`define SPI_CS_BIT	5		// address bit holding the card select
`define SPI_KEEP_BIT	6		// address bit set: keep shift reg, no load

`endif

// ==== hdl/io_bus_pkg.sv ====
`include "io_bus_config.svh"

package io_bus_pkg;

	// ----------------------------------------
	// bus payload types
	// ----------------------------------------

	typedef logic [`IO_ADDR_W-1:0] io_addr_t;		// full io address
	typedef logic [`IO_DATA_W-1:0] io_data_t;		// one data byte

	// ----------------------------------------
	// target device of a request
	// ----------------------------------------

	typedef enum logic [1:0]
	{
		DEV_NONE = 2'd0,	// unmapped, reads give bus-free value
		DEV_SPI  = 2'd1,	// mmc serial shifter
		DEV_PPI  = 2'd2		// parallel port
	} io_dev_e;

endpackage

// ==== hdl/io_bus_top.sv ====
module io_bus_top
(
	input	logic					sys_clk,	// system clock
	input	logic					z_reset_n,	// async reset, active low
	input	logic					io_valid,	// cpu request
	input	io_bus_pkg::io_addr_t	io_addr,	// io address
	input	logic					io_wr,		// 1 write, 0 read
	input	io_bus_pkg::io_data_t	io_wdata,	// write data
	input	io_bus_pkg::io_data_t	status_in,	// port B inputs
	input	logic					mmc_din,	// card data out
	output	logic					io_ready,	// request taken when high
	output	logic					resp_valid,	// read response pulse
	output	io_bus_pkg::io_data_t	resp_data,	// read response data
	output	io_bus_pkg::io_data_t	ppi_a,		// port A latch
	output	io_bus_pkg::io_data_t	ppi_c,		// port C latch
	output	logic					mmc_clk,	// card clock
	output	logic					mmc_cs_n,	// card select
	output	logic					mmc_dout	// card data in
);

	import io_bus_pkg::*;

	logic		spi_busy;	// serial transfer running
	logic		spi_stb;	// decode to shifter
	logic		ppi_stb;	// decode to parallel port
	logic		rd_acc;		// decode to result stage
	io_dev_e	dev_sel;	// read target
	io_data_t	spi_rdata;	// shifter read value
	io_data_t	ppi_rdata;	// parallel port read value

	// ----------------------------------------
	// decode stage
	// ----------------------------------------

	io_decode i_decode (
		.sys_clk(sys_clk), .z_reset_n(z_reset_n),
		.io_valid(io_valid), .io_addr(io_addr), .io_wr(io_wr),
		.spi_busy(spi_busy), .io_ready(io_ready),
		.spi_stb(spi_stb), .ppi_stb(ppi_stb),
		.rd_acc(rd_acc), .dev_sel(dev_sel)
	);

	// ----------------------------------------
	// execute units
	// ----------------------------------------

	spi_shifter i_spi (
		.sys_clk(sys_clk), .z_reset_n(z_reset_n),
		.spi_stb(spi_stb), .io_addr(io_addr), .io_wr(io_wr), .io_wdata(io_wdata),
		.mmc_din(mmc_din), .spi_busy(spi_busy), .spi_rdata(spi_rdata),
		.mmc_clk(mmc_clk), .mmc_cs_n(mmc_cs_n), .mmc_dout(mmc_dout)
	);

	ppi_ports i_ppi (
		.sys_clk(sys_clk), .z_reset_n(z_reset_n),
		.ppi_stb(ppi_stb), .io_addr(io_addr), .io_wr(io_wr), .io_wdata(io_wdata),
		.status_in(status_in), .ppi_rdata(ppi_rdata),
		.ppi_a(ppi_a), .ppi_c(ppi_c)
	);

	// ----------------------------------------
	// result stage
	// ----------------------------------------

	read_mux i_rmux (
		.sys_clk(sys_clk), .z_reset_n(z_reset_n),
		.rd_acc(rd_acc), .dev_sel(dev_sel),
		.spi_rdata(spi_rdata), .ppi_rdata(ppi_rdata),
		.resp_valid(resp_valid), .resp_data(resp_data)
	);

endmodule

// ==== hdl/io_decode.sv ====
`include "io_bus_config.svh"

module io_decode
(
	input	logic					sys_clk,	// system clock
	input	logic					z_reset_n,	// async reset, active low
	input	logic					io_valid,	// request present
	input	io_bus_pkg::io_addr_t	io_addr,	// request address
	input	logic					io_wr,		// 1 write, 0 read
	input	logic					spi_busy,	// shifter still clocking
	output	logic					io_ready,	// request can be taken
	output	logic					spi_stb,	// access to serial window
	output	logic					ppi_stb,	// access to parallel port
	output	logic					rd_acc,		// read accepted this cycle
	output	io_bus_pkg::io_dev_e	dev_sel		// target of current request
);

	import io_bus_pkg::*;

	logic	[`IO_PAGE_W-1:0]	page;		// high address byte
	io_dev_e				dev;		// decoded target
	logic					accept;		// valid and ready together

	// ----------------------------------------
	// decode
	// ----------------------------------------

	assign page = io_addr[`IO_ADDR_W-1 -: `IO_PAGE_W];

	always_comb
	begin
		if (page == `IO_SPI_PAGE)
			dev = DEV_SPI;		// serial window
		else if (page == `IO_PPI_PAGE)
			dev = DEV_PPI;		// 8255 subset
		else
			dev = DEV_NONE;	// nobody answers
	end

	// only the serial window ever waits, and only while shifting
	assign io_ready = !((dev == DEV_SPI) && spi_busy);
	assign accept   = io_valid && io_ready;

	// ----------------------------------------
	// strobes
	// ----------------------------------------

	assign spi_stb = accept && (dev == DEV_SPI);	// one device at most
	assign ppi_stb = accept && (dev == DEV_PPI);
	assign rd_acc  = accept && !io_wr;			// response one cycle later
	assign dev_sel = dev;					// result stage picks data

endmodule

// ==== hdl/ppi_ports.sv ====
`include "io_bus_config.svh"

module ppi_ports
(
	input	logic					sys_clk,	// system clock
	input	logic					z_reset_n,	// async reset, active low
	input	logic					ppi_stb,	// access to parallel port
	input	io_bus_pkg::io_addr_t	io_addr,	// bits 1..0 select the port
	input	logic					io_wr,		// 1 write, 0 read
	input	io_bus_pkg::io_data_t	io_wdata,	// port data or command
	input	io_bus_pkg::io_data_t	status_in,	// port B inputs
	output	io_bus_pkg::io_data_t	ppi_rdata,	// read value for address
	output	io_bus_pkg::io_data_t	ppi_a,		// port A latch
	output	io_bus_pkg::io_data_t	ppi_c		// port C latch
);

	import io_bus_pkg::*;

	io_data_t		a_q;		// port A output latch
	io_data_t		c_q;		// port C output latch
	logic	[1:0]	port;		// register select
	logic			wr_stb;		// write to this device

	assign port   = io_addr[1:0];
	assign wr_stb = ppi_stb && io_wr;

	// ----------------------------------------
	// output latches
	// ----------------------------------------

	always_ff @(posedge sys_clk or negedge z_reset_n)
	begin
		if (!z_reset_n)
		begin
			a_q <= '0;
			c_q <= '0;
		end
		else if (wr_stb)
		begin
			case (port)
				2'd0:	a_q <= io_wdata;		// port A
				2'd2:	c_q <= io_wdata;		// port C
				2'd3:
				begin
					if (io_wdata[7])
					begin
						// mode word, all outputs back to zero
						a_q <= '0;
						c_q <= '0;
					end
					else
						c_q[io_wdata[3:1]] <= io_wdata[0];	// bit set/reset
				end
				default: ;					// port B is input only
			endcase
		end
	end

	// ----------------------------------------
	// read side
	// ----------------------------------------

	always_comb
	begin
		case (port)
			2'd0:		ppi_rdata = a_q;
			2'd1:		ppi_rdata = status_in;	// live status
			2'd2:		ppi_rdata = c_q;
			default:	ppi_rdata = `IO_BUS_FREE;	// control reg not readable
		endcase
	end

	assign ppi_a = a_q;
	assign ppi_c = c_q;

endmodule

// ==== hdl/read_mux.sv ====
`include "io_bus_config.svh"

module read_mux
(
	input	logic					sys_clk,	// system clock
	input	logic					z_reset_n,	// async reset, active low
	input	logic					rd_acc,		// read accepted this cycle
	input	io_bus_pkg::io_dev_e	dev_sel,	// device being read
	input	io_bus_pkg::io_data_t	spi_rdata,	// shift register
	input	io_bus_pkg::io_data_t	ppi_rdata,	// parallel port value
	output	logic					resp_valid,	// one-cycle response pulse
	output	io_bus_pkg::io_data_t	resp_data	// read result
);

	import io_bus_pkg::*;

	io_data_t	sel_data;	// value of addressed device

	// ----------------------------------------
	// select
	// ----------------------------------------

	always_comb
	begin
		case (dev_sel)
			DEV_SPI:	sel_data = spi_rdata;
			DEV_PPI:	sel_data = ppi_rdata;
			default:	sel_data = `IO_BUS_FREE;	// pull-up on bus
		endcase
	end

	// ----------------------------------------
	// response register
	// ----------------------------------------

	always_ff @(posedge sys_clk or negedge z_reset_n)
	begin
		if (!z_reset_n)
			resp_valid <= 1'b0;
		else
			resp_valid <= rd_acc;		// no ready, cpu always takes it
	end

	// sampled on the accept edge, before any write on it
	always_ff @(posedge sys_clk)
	begin
		if (rd_acc)
			resp_data <= sel_data;
	end

endmodule

// ==== hdl/spi_shifter.sv ====
`include "io_bus_config.svh"

module spi_shifter
(
	input	logic					sys_clk,	// system clock
	input	logic					z_reset_n,	// async reset, active low
	input	logic					spi_stb,	// access to serial window
	input	io_bus_pkg::io_addr_t	io_addr,	// count, select, keep bits
	input	logic					io_wr,		// write starts a transfer
	input	io_bus_pkg::io_data_t	io_wdata,	// byte to send
	input	logic					mmc_din,	// card data out
	output	logic					spi_busy,	// bits still to go
	output	io_bus_pkg::io_data_t	spi_rdata,	// shift register
	output	logic					mmc_clk,	// card clock, idles low
	output	logic					mmc_cs_n,	// card select, active low
	output	logic					mmc_dout	// card data in
);

	import io_bus_pkg::*;

	localparam logic [`SPI_CNT_W-1:0] cnt_one = 1;	// count step

	logic	[`SPI_CNT_W-1:0]	spi_cnt;	// bits left
	logic					cs_q;		// card selected
	logic					clk_q;		// serial clock phase
	io_data_t				sreg;		// shift register
	logic					load;		// cpu write to window

	assign load     = spi_stb && io_wr;
	assign spi_busy = (spi_cnt != '0);

	// ----------------------------------------
	// count, select and clock phase
	// ----------------------------------------

	always_ff @(posedge sys_clk or negedge z_reset_n)
	begin
		if (!z_reset_n)
		begin
			spi_cnt <= '0;
			cs_q    <= 1'b0;		// card deselected
			clk_q   <= 1'b0;		// clock idles low
		end
		else if (load)
		begin
			spi_cnt <= io_addr[`SPI_CNT_W-1:0];	// bits 3..0
			cs_q    <= io_addr[`SPI_CS_BIT];
		end
		else if (spi_busy)
		begin
			clk_q <= ~clk_q;				// toggle each cycle
			if (clk_q)
				spi_cnt <= spi_cnt - cnt_one;	// falling phase ends a bit
		end
	end

	// ----------------------------------------
	// shift register
	// ----------------------------------------

	always_ff @(posedge sys_clk)
	begin
		if (load)
		begin
			if (!io_addr[`SPI_KEEP_BIT])
				sreg <= io_wdata;		// new byte to send
		end
		else if (spi_busy && !clk_q)
			sreg <= {mmc_din, sreg[`IO_DATA_W-1:1]};	// rising phase, lsb first
	end

	assign spi_rdata = sreg;
	assign mmc_clk   = clk_q;
	assign mmc_cs_n  = ~cs_q;
	assign mmc_dout  = sreg[0];	// next bit out

endmodule

// ==== io_bus_top.f ====
+incdir+hdl
hdl/io_bus_pkg.sv
hdl/io_decode.sv
hdl/spi_shifter.sv
hdl/ppi_ports.sv
hdl/read_mux.sv
hdl/io_bus_top.sv
verif/tb_clock.sv
verif/tb_io_bus.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the I/O bus testbench with Verilator.
# The exit status is nonzero when the testbench stops on an error.
set -e

cd "$(dirname "$0")"

verilator --binary -j 0 -f io_bus_top.f --top-module tb_io_bus -Mdir obj_dir

./obj_dir/Vtb_io_bus

// ==== verif/tb_clock.sv ====
module tb_clock
#(
	parameter int period       = 8,	// clock period in time units
	parameter int reset_cycles = 4	// cycles with reset held low
)
(
	output	logic	sys_clk,	// free-running clock
	output	logic	z_reset_n	// async reset, active low
);

	initial
	begin
		sys_clk = 1'b0;
		forever #(period / 2) sys_clk = ~sys_clk;
	end

	// release on a falling edge, away from the flops' active edge
	initial
	begin
		z_reset_n = 1'b0;
		repeat (reset_cycles) @(negedge sys_clk);
		z_reset_n = 1'b1;
	end

endmodule

// ==== verif/tb_io_bus.sv ====
`include "io_bus_config.svh"

module tb_io_bus;

	import io_bus_pkg::*;

	localparam int timeout_cycles = 200;	// limit of every wait loop
	localparam int settle         = 1;		// sample point inside the low phase

	logic		sys_clk;
	logic		z_reset_n;
	logic		io_valid;
	io_addr_t	io_addr;
	logic		io_wr;
	io_data_t	io_wdata;
	io_data_t	status_in;
	logic		mmc_din = 1'b0;		// driven by the card model
	logic		io_ready;
	logic		resp_valid;
	io_data_t	resp_data;
	io_data_t	ppi_a;
	io_data_t	ppi_c;
	logic		mmc_clk;
	logic		mmc_cs_n;
	logic		mmc_dout;

	int				seed = 35110;
	logic	[31:0]	rand_word;
	io_data_t		exp_a;				// expected port A latch
	io_data_t		exp_c;				// expected port C latch
	io_data_t		card_byte;			// what the card sends back
	io_data_t		card_rx = '0;		// what the card got
	int				card_rx_bits = 0;
	logic	[3:0]	card_tx_idx = '0;
	logic			prev_mmc_clk = 1'b0;
	logic			prev_mmc_dout = 1'b0;
	io_data_t		resp_q[$];			// every response seen, in order
	int				rd_idx;				// next response to check

	tb_clock #(.period(8), .reset_cycles(4)) i_clock (.sys_clk(sys_clk), .z_reset_n(z_reset_n));

	io_bus_top i_dut (
		.sys_clk(sys_clk), .z_reset_n(z_reset_n),
		.io_valid(io_valid), .io_addr(io_addr), .io_wr(io_wr), .io_wdata(io_wdata),
		.status_in(status_in), .mmc_din(mmc_din),
		.io_ready(io_ready), .resp_valid(resp_valid), .resp_data(resp_data),
		.ppi_a(ppi_a), .ppi_c(ppi_c),
		.mmc_clk(mmc_clk), .mmc_cs_n(mmc_cs_n), .mmc_dout(mmc_dout)
	);

	// ----------------------------------------
	// response collector and mmc card model
	// ----------------------------------------

	always @(negedge sys_clk)
	begin
		if (resp_valid === 1'b1)
			resp_q.push_back(resp_data);		// one entry per pulse cycle
	end

	// looks at the card clock each low phase of sys_clk
	always @(negedge sys_clk)
	begin
		if (mmc_cs_n !== 1'b0)
		begin
			card_tx_idx  = '0;
			card_rx_bits = 0;
			mmc_din      = card_byte[0];		// first bit ready before select
		end
		else
		begin
			if (mmc_clk && !prev_mmc_clk)		// card clock rose, take dout
			begin
				card_rx      = {prev_mmc_dout, card_rx[7:1]};
				card_rx_bits = card_rx_bits + 1;
			end
			if (!mmc_clk && prev_mmc_clk)		// card clock fell, next bit
			begin
				card_tx_idx = card_tx_idx + 4'd1;
				mmc_din     = card_byte[card_tx_idx[2:0]];
			end
		end
		prev_mmc_clk  = mmc_clk;
		prev_mmc_dout = mmc_dout;			// value held up to the rise
	end

	// ----------------------------------------
	// checks and bus helpers
	// ----------------------------------------

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("STATUS: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_data(input string name, input io_data_t got, input io_data_t exp);
		if (got !== exp)
			report_failure($sformatf("FAIL at %0t: %s is %h, expected %h", $time, name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			report_failure($sformatf("FAIL at %0t: %s is %b, expected %b", $time, name, got, exp));
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp)
			report_failure($sformatf("FAIL at %0t: %s is %0d, expected %0d", $time, name, got, exp));
	endtask

	function automatic io_addr_t ppi_addr(input logic [1:0] port);
		return {`IO_PPI_PAGE, 6'd0, port};
	endfunction

	task automatic wait_reset_release();
		int waited;
		waited = 0;
		while (z_reset_n !== 1'b1)
		begin
			waited++;
			if (waited > timeout_cycles)
				report_failure("reset was never released");
			@(posedge sys_clk);
		end
		@(negedge sys_clk);
	endtask

	// called on a falling edge, returns on the falling edge after acceptance
	task automatic bus_req(input io_addr_t addr, input logic wr, input io_data_t wdata,
		output int stalls);
		int waited;
		waited   = 0;
		io_valid = 1'b1;
		io_addr  = addr;
		io_wr    = wr;
		io_wdata = wdata;
		#settle;
		while (io_ready !== 1'b1)
		begin
			waited++;
			if (waited > timeout_cycles)
				report_failure("request was never accepted, io_ready stayed low");
			@(negedge sys_clk);
			#settle;
		end
		stalls = waited;
		@(posedge sys_clk);		// accept edge
		@(negedge sys_clk);
	endtask

	task automatic bus_idle();
		io_valid = 1'b0;
		io_wr    = 1'b0;
	endtask

	task automatic wait_resp(input io_data_t exp, input string name);
		int waited;
		waited = 0;
		#settle;
		while (resp_q.size() <= rd_idx)
		begin
			waited++;
			if (waited > timeout_cycles)
				report_failure("a read got no response");
			@(negedge sys_clk);
			#settle;
		end
		check_data(name, resp_q[rd_idx], exp);
		rd_idx++;
		@(negedge sys_clk);
	endtask

	task automatic write_reg(input io_addr_t addr, input io_data_t data);
		int stalls;
		bus_req(addr, 1'b1, data, stalls);
		bus_idle();
	endtask

	task automatic read_expect(input io_addr_t addr, input io_data_t exp, input string name);
		int stalls;
		bus_req(addr, 1'b0, 8'h00, stalls);
		bus_idle();
		wait_resp(exp, name);
	endtask

	// ----------------------------------------
	// directed tests
	// ----------------------------------------

	task automatic test_after_reset();
		check_bit("io_ready", io_ready, 1'b1);
		check_bit("resp_valid", resp_valid, 1'b0);
		check_bit("mmc_cs_n", mmc_cs_n, 1'b1);
		check_bit("mmc_clk", mmc_clk, 1'b0);
		check_data("ppi_a", ppi_a, 8'h00);
		check_data("ppi_c", ppi_c, 8'h00);
		read_expect(ppi_addr(2'd0), 8'h00, "resp_data (port A)");
		read_expect(ppi_addr(2'd2), 8'h00, "resp_data (port C)");
	endtask

	task automatic test_unmapped();
		int i;
		logic [7:0] page;
		read_expect(16'h0D00, 8'hFF, "resp_data (page 0D)");	// neighbours of both pages
		read_expect(16'h0F33, 8'hFF, "resp_data (page 0F)");
		read_expect(16'h1903, 8'hFF, "resp_data (page 19)");
		read_expect(16'h1B01, 8'hFF, "resp_data (page 1B)");
		for (i = 0; i < 4; i++)
		begin
			rand_word = $random(seed);
			page      = rand_word[15:8];
			if (page == `IO_SPI_PAGE || page == `IO_PPI_PAGE)
				page = page ^ 8'h80;			// keep it unmapped
			read_expect({page, rand_word[7:0]}, 8'hFF, "resp_data (unmapped)");
		end
		read_expect(ppi_addr(2'd3), 8'hFF, "resp_data (port 3)");
	endtask

	task automatic test_latches();
		exp_a     = 8'h5A;
		rand_word = $random(seed);
		exp_c     = rand_word[7:0];
		write_reg(ppi_addr(2'd0), exp_a);
		check_data("ppi_a", ppi_a, exp_a);
		write_reg(ppi_addr(2'd2), exp_c);
		check_data("ppi_c", ppi_c, exp_c);
		write_reg(ppi_addr(2'd1), ~exp_a);	// input port, write goes nowhere
		check_data("ppi_a", ppi_a, exp_a);
		check_data("ppi_c", ppi_c, exp_c);
		read_expect(ppi_addr(2'd0), exp_a, "resp_data (port A)");
		read_expect(ppi_addr(2'd2), exp_c, "resp_data (port C)");
		status_in = rand_word[15:8];
		read_expect(ppi_addr(2'd1), status_in, "resp_data (port B)");
	endtask

	task automatic test_bit_set_reset();
		int i;
		logic [2:0] bit_sel;
		for (i = 0; i < 8; i++)
		begin
			rand_word      = $random(seed);
			bit_sel        = i[2:0];
			exp_c[bit_sel] = rand_word[0];		// only the named bit moves
			write_reg(ppi_addr(2'd3), {1'b0, rand_word[6:4], bit_sel, rand_word[0]});
			check_data("ppi_c", ppi_c, exp_c);
			check_data("ppi_a", ppi_a, exp_a);
		end
		read_expect(ppi_addr(2'd2), exp_c, "resp_data (port C)");
		rand_word = $random(seed);
		write_reg(ppi_addr(2'd3), {1'b1, rand_word[6:0]});	// mode word
		exp_a = 8'h00;
		exp_c = 8'h00;
		check_data("ppi_a", ppi_a, exp_a);
		check_data("ppi_c", ppi_c, exp_c);
	endtask

	task automatic test_serial();
		int stalls;
		io_data_t tx_byte;
		rand_word = $random(seed);
		tx_byte   = rand_word[7:0];
		bus_req({`IO_SPI_PAGE, 8'h28}, 1'b1, tx_byte, stalls);	// load, select, 8 bits
		check_count("stall cycles of serial write", stalls, 0);
		check_bit("mmc_cs_n", mmc_cs_n, 1'b0);
		exp_a = ~tx_byte;
		bus_req(ppi_addr(2'd0), 1'b1, exp_a, stalls);		// slips past the busy shifter
		check_count("stall cycles of port A write", stalls, 0);
		check_data("ppi_a", ppi_a, exp_a);
		bus_req({`IO_SPI_PAGE, 8'h28}, 1'b0, 8'h00, stalls);
		bus_idle();
		check_count("stall cycles of serial read", stalls, 2 * 8 - 1);	// one went to port A
		check_bit("mmc_clk", mmc_clk, 1'b0);
		check_count("card_rx_bits", card_rx_bits, 8);
		check_data("card_rx", card_rx, tx_byte);
		wait_resp(card_byte, "resp_data (serial)");
	endtask

	task automatic test_back_to_back();
		int stalls;
		int total;
		total     = 0;
		rand_word = $random(seed);
		status_in = rand_word[7:0];
		exp_c     = rand_word[15:8];
		write_reg(ppi_addr(2'd2), exp_c);
		bus_req(ppi_addr(2'd0), 1'b0, 8'h00, stalls);	// one accept per cycle
		total += stalls;
		bus_req({`IO_SPI_PAGE, 8'h00}, 1'b0, 8'h00, stalls);
		total += stalls;
		bus_req(16'h4200, 1'b0, 8'h00, stalls);
		total += stalls;
		bus_req(ppi_addr(2'd1), 1'b0, 8'h00, stalls);
		total += stalls;
		bus_req(ppi_addr(2'd2), 1'b0, 8'h00, stalls);
		total += stalls;
		bus_idle();
		check_count("stall cycles of back-to-back reads", total, 0);
		wait_resp(exp_a, "resp_data (port A)");
		wait_resp(card_byte, "resp_data (serial)");
		wait_resp(8'hFF, "resp_data (unmapped)");
		wait_resp(status_in, "resp_data (port B)");
		wait_resp(exp_c, "resp_data (port C)");
	endtask

	initial
	begin
		io_valid  = 1'b0;
		io_addr   = '0;
		io_wr     = 1'b0;
		io_wdata  = '0;
		status_in = '0;
		rd_idx    = 0;
		exp_a     = '0;
		exp_c     = '0;
		rand_word = $random(seed);
		card_byte = rand_word[7:0];
		wait_reset_release();
		test_after_reset();
		test_unmapped();
		test_latches();
		test_bit_set_reset();
		test_serial();
		test_back_to_back();
		repeat (4) @(negedge sys_clk);		// quiet bus, no stray responses
		if (resp_q.size() != rd_idx)
			report_failure("more read responses came back than reads were issued");
		else
		begin
			$display("STATUS: PASS");
			$finish;
		end
	end

endmodule
